// File: cache_subsys.f
+incdir+dv
hdl/cache_pkg.sv
hdl/mem_pkg.sv
hdl/cache_line_store.sv
hdl/l1_cache_ctrl.sv
hdl/backing_memory.sv
hdl/cache_subsys_top.sv
dv/cache_subsys_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= cache_subsys_tb
FILELIST  ?= cache_subsys.f

.PHONY: sim clean

# Build, run, and pass only if the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -x 'Regression passed' > /dev/null

clean:
	rm -rf obj_dir

// File: dv/cache_test_table.svh
`ifndef cache_test_table_svh
`define cache_test_table_svh

    // Columns: operation, address, store data, hit in first cycle, name
    task automatic fill_test_table();
        // Set 1
        add_test(op_load,  32'h0000_0010, 32'h0000_0000, 1'b0, "cold_load_miss");
        add_test(op_load,  32'h0000_0014, 32'h0000_0000, 1'b1, "same_line_hit");
        add_test(op_store, 32'h0000_0018, 32'h1234_abcd, 1'b1, "store_hit");
        add_test(op_load,  32'h0000_0018, 32'h0000_0000, 1'b1, "load_after_store");

        // Set 2: A, B, A again, then C pushes out B
        add_test(op_load,  32'h0000_0020, 32'h0000_0000, 1'b0, "lru_fill_a");
        add_test(op_load,  32'h0000_00a0, 32'h0000_0000, 1'b0, "lru_fill_b");
        add_test(op_load,  32'h0000_0024, 32'h0000_0000, 1'b1, "lru_touch_a");
        add_test(op_load,  32'h0000_0120, 32'h0000_0000, 1'b0, "lru_fill_c");
        add_test(op_load,  32'h0000_0028, 32'h0000_0000, 1'b1, "lru_a_kept");
        add_test(op_load,  32'h0000_00a4, 32'h0000_0000, 1'b0, "lru_b_evicted");

        // Set 3: dirty line, two conflicting lines, then reload
        add_test(op_store, 32'h0000_0030, 32'hdead_0030, 1'b0, "store_miss");
        add_test(op_store, 32'h0000_003c, 32'h5a5a_003c, 1'b1, "store_same_line");
        add_test(op_load,  32'h0000_00b0, 32'h0000_0000, 1'b0, "conflict_first");
        add_test(op_load,  32'h0000_0130, 32'h0000_0000, 1'b0, "conflict_write_back");
        add_test(op_load,  32'h0000_0030, 32'h0000_0000, 1'b0, "reload_dirty_word");
        add_test(op_load,  32'h0000_003c, 32'h0000_0000, 1'b1, "reload_second_word");
        add_test(op_load,  32'h0000_0034, 32'h0000_0000, 1'b1, "reload_clean_word");

        // Earlier set left alone
        add_test(op_load,  32'h0000_0018, 32'h0000_0000, 1'b1, "set1_still_held");
    endtask

`endif

// File: dv/cache_subsys_tb.sv
`timescale 1ns/1ps

module cache_subsys_tb;

    localparam int clk_period_ns     = 100;
    localparam int worst_miss_cycles = 27;
    localparam int stuck_limit       = 2 * worst_miss_cycles;
    localparam int random_ops        = 200;
    localparam cache_pkg::word_t lcg_seed = 32'd25673;

    typedef enum logic {
        op_load,
        op_store
    } op_t;

    typedef struct {
        op_t              op;
        cache_pkg::word_t addr;
        cache_pkg::word_t data;
        logic             exp_hit;
        string            name;
    } test_entry_t;

    logic             clk;
    logic             rst_n;
    logic             load;
    logic             store;
    cache_pkg::word_t address;
    cache_pkg::word_t data_in;
    logic             hit;
    logic             miss;
    logic             busy;
    cache_pkg::word_t data_out;

    test_entry_t      tests[$];
    bit               table_loaded = 1'b0;
    cache_pkg::word_t lcg_state;
    int               error_count  = 0;
    int               check_count  = 0;
    int               tests_run    = 0;
    int               tests_failed = 0;

    // Flat view of memory as the processor should see it
    cache_pkg::word_t ref_mem [mem_pkg::mem_words];

    cache_subsys_top cache_subsys_top_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (load),
        .store    (store),
        .address  (address),
        .data_in  (data_in),
        .hit      (hit),
        .miss     (miss),
        .busy     (busy),
        .data_out (data_out)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period_ns / 2) clk = ~clk;
    end

    function automatic cache_pkg::word_t lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic add_test(input op_t op, input cache_pkg::word_t addr,
                            input cache_pkg::word_t data, input logic exp_hit,
                            input string name);
        test_entry_t entry;
        entry.op      = op;
        entry.addr    = addr;
        entry.data    = data;
        entry.exp_hit = exp_hit;
        entry.name    = name;
        tests.push_back(entry);
    endtask

    `include "cache_test_table.svh"

    task automatic check_word(input cache_pkg::word_t got, input cache_pkg::word_t exp,
                              input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("mismatch at %0t: %s, got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input bit clean);
        tests_run++;
        if (clean) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED", name);
        end
    endtask

    // Holds the request until hit, sampling on the falling edge
    task automatic run_request(input op_t op, input cache_pkg::word_t addr,
                               input cache_pkg::word_t wdata, input logic check_first,
                               input logic exp_hit, input string name,
                               output bit completed);
        int waited;
        int idx;
        waited    = 0;
        idx       = int'(addr[11:2]);
        completed = 1'b0;
        @(posedge clk);
        #1;
        load    = (op == op_load);
        store   = (op == op_store);
        address = addr;
        data_in = wdata;
        @(negedge clk);
        check_flag(busy, 1'b0, "busy in first cycle");
        if (check_first) begin
            check_flag(hit, exp_hit, "hit in first cycle");
            check_flag(miss, !exp_hit, "miss in first cycle");
        end
        if (!hit) begin
            @(negedge clk);
            check_flag(busy, 1'b1, "busy after miss");
        end
        while (!hit && waited < stuck_limit) begin
            @(negedge clk);
            waited++;
        end
        if (hit) begin
            // Stores show the old word until the edge
            check_word(data_out, ref_mem[idx], "data on hit cycle");
            if (op == op_store) begin
                ref_mem[idx] = wdata;
            end
            completed = 1'b1;
        end else begin
            error_count++;
            $display("%s: request stuck busy at %0t, no hit after %0d cycles",
                     name, $time, waited);
        end
        @(posedge clk);
        #1;
        load  = 1'b0;
        store = 1'b0;
    endtask

    initial begin
        int                  errors_before;
        bit                  completed;
        bit                  aborted;
        cache_pkg::word_t    r;
        cache_pkg::word_t    addr;
        cache_pkg::word_t    wdata;
        cache_pkg::set_idx_t set_sel;
        op_t                 op;
        rst_n     = 1'b0;
        load      = 1'b0;
        store     = 1'b0;
        address   = '0;
        data_in   = '0;
        lcg_state = lcg_seed;
        aborted   = 1'b0;
        for (int i = 0; i < mem_pkg::mem_words; i++) begin
            ref_mem[i] = mem_pkg::mem_init_word(mem_pkg::mem_addr_t'(i));
        end
        fill_test_table();
        table_loaded = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int i = 0; i < tests.size() && !aborted; i++) begin
            errors_before = error_count;
            run_request(tests[i].op, tests[i].addr, tests[i].data, 1'b1,
                        tests[i].exp_hit, tests[i].name, completed);
            report_test(tests[i].name, error_count == errors_before);
            aborted = !completed;
        end

        // Sets 4 to 6 only, so tags collide often
        if (!aborted) begin
            errors_before = error_count;
            for (int n = 0; n < random_ops && !aborted; n++) begin
                r       = lcg_next();
                set_sel = cache_pkg::set_idx_t'(4 + (r[15:8] % 3));
                addr    = {20'h0, r[20:16], set_sel, r[25:24], 2'b00};
                op      = r[30] ? op_store : op_load;
                wdata   = lcg_next();
                run_request(op, addr, wdata, 1'b0, 1'b0, "random", completed);
                aborted = !completed;
            end
            report_test("random_phase", error_count == errors_before);
        end

        $display("%0d tests, %0d failing, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        longint limit_ns;
        wait (table_loaded);
        limit_ns = longint'(tests.size() + random_ops) * worst_miss_cycles * 2 * clk_period_ns;
        #(limit_ns);
        $display("watchdog expired at %0t, the run did not finish in time", $time);
        $display("Regression failed");
        $finish;
    end

endmodule

// File: hdl/cache_subsys_top.sv
`timescale 1ns/1ps

module cache_subsys_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             load,
    input  logic             store,
    input  cache_pkg::word_t address,
    input  cache_pkg::word_t data_in,
    output logic             hit,
    output logic             miss,
    output logic             busy,
    output cache_pkg::word_t data_out
);

    // Controller to backing memory
    logic               mem_read;
    logic               mem_write;
    mem_pkg::mem_addr_t mem_addr;
    cache_pkg::word_t   mem_write_data;
    cache_pkg::word_t   mem_data;
    logic               mem_ready;

    // Controller to line store
    cache_pkg::tag_t      lookup_tag;
    cache_pkg::set_idx_t  lookup_set;
    logic                 rd_way;
    cache_pkg::word_idx_t rd_word;
    logic                 wr_en;
    logic                 wr_way;
    cache_pkg::word_idx_t wr_word;
    cache_pkg::word_t     wr_data;
    logic                 set_dirty;
    logic                 install_en;
    logic                 install_way;
    logic                 lru_touch;
    logic                 touched_way;

    // Line store to controller
    logic             line_hit;
    logic             hit_way;
    logic             victim_way;
    logic             victim_valid;
    logic             victim_dirty;
    cache_pkg::tag_t  victim_tag;
    cache_pkg::word_t rd_data;

    l1_cache_ctrl l1_cache_ctrl_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .load           (load),
        .store          (store),
        .address        (address),
        .data_in        (data_in),
        .hit            (hit),
        .miss           (miss),
        .busy           (busy),
        .data_out       (data_out),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .mem_addr       (mem_addr),
        .mem_write_data (mem_write_data),
        .mem_data       (mem_data),
        .mem_ready      (mem_ready),
        .lookup_tag     (lookup_tag),
        .lookup_set     (lookup_set),
        .rd_way         (rd_way),
        .rd_word        (rd_word),
        .wr_en          (wr_en),
        .wr_way         (wr_way),
        .wr_word        (wr_word),
        .wr_data        (wr_data),
        .set_dirty      (set_dirty),
        .install_en     (install_en),
        .install_way    (install_way),
        .lru_touch      (lru_touch),
        .touched_way    (touched_way),
        .line_hit       (line_hit),
        .hit_way        (hit_way),
        .victim_way     (victim_way),
        .victim_valid   (victim_valid),
        .victim_dirty   (victim_dirty),
        .victim_tag     (victim_tag),
        .rd_data        (rd_data)
    );

    cache_line_store cache_line_store_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup_tag   (lookup_tag),
        .lookup_set   (lookup_set),
        .hit          (line_hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_valid (victim_valid),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .rd_way       (rd_way),
        .rd_word      (rd_word),
        .rd_data      (rd_data),
        .wr_en        (wr_en),
        .wr_way       (wr_way),
        .wr_word      (wr_word),
        .wr_data      (wr_data),
        .set_dirty    (set_dirty),
        .install_en   (install_en),
        .install_way  (install_way),
        .lru_touch    (lru_touch),
        .touched_way  (touched_way)
    );

    backing_memory backing_memory_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .mem_addr       (mem_addr),
        .mem_write_data (mem_write_data),
        .mem_data       (mem_data),
        .mem_ready      (mem_ready)
    );

endmodule

// File: hdl/backing_memory.sv
`timescale 1ns/1ps

module backing_memory (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               mem_read,
    input  logic               mem_write,
    input  mem_pkg::mem_addr_t mem_addr,
    input  cache_pkg::word_t   mem_write_data,
    output cache_pkg::word_t   mem_data,
    output logic               mem_ready
);

    cache_pkg::word_t mem_q [mem_pkg::mem_words];

    logic [mem_pkg::mem_lat_width-1:0] lat_cnt;
    logic               read_q;
    logic               write_q;
    mem_pkg::mem_addr_t addr_q;
    logic               served_q;

    logic active;
    logic changed;
    logic fire;

    assign active  = mem_read || mem_write;
    assign changed = (mem_read != read_q) || (mem_write != write_q) || (mem_addr != addr_q);

    // One access per steady request, lat_cnt counts cycles already steady
    assign fire = active && !changed && !served_q &&
                  (lat_cnt == mem_pkg::mem_lat_width'(mem_pkg::mem_latency - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_q    <= 1'b0;
            write_q   <= 1'b0;
            addr_q    <= '0;
            lat_cnt   <= '0;
            served_q  <= 1'b0;
            mem_ready <= 1'b0;
        end else begin
            read_q    <= mem_read;
            write_q   <= mem_write;
            addr_q    <= mem_addr;
            mem_ready <= fire;
            if (!active) begin
                lat_cnt  <= '0;
                served_q <= 1'b0;
            end else if (changed) begin
                lat_cnt  <= mem_pkg::mem_lat_width'(1);
                served_q <= 1'b0;
            end else if (fire) begin
                served_q <= 1'b1;
            end else if (!served_q) begin
                lat_cnt <= lat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < mem_pkg::mem_words; i++) begin
                mem_q[i] <= mem_pkg::mem_init_word(mem_pkg::mem_addr_t'(i));
            end
        end else if (fire && mem_write) begin
            mem_q[mem_addr] <= mem_write_data;
        end
    end

    // Read word is valid alongside the ready pulse
    always_ff @(posedge clk) begin
        if (fire && mem_read) begin
            mem_data <= mem_q[mem_addr];
        end
    end

endmodule

// File: hdl/l1_cache_ctrl.sv
`timescale 1ns/1ps

module l1_cache_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 load,
    input  logic                 store,
    input  cache_pkg::word_t     address,
    input  cache_pkg::word_t     data_in,
    output logic                 hit,
    output logic                 miss,
    output logic                 busy,
    output cache_pkg::word_t     data_out,
    output logic                 mem_read,
    output logic                 mem_write,
    output mem_pkg::mem_addr_t   mem_addr,
    output cache_pkg::word_t     mem_write_data,
    input  cache_pkg::word_t     mem_data,
    input  logic                 mem_ready,
    output cache_pkg::tag_t      lookup_tag,
    output cache_pkg::set_idx_t  lookup_set,
    output logic                 rd_way,
    output cache_pkg::word_idx_t rd_word,
    output logic                 wr_en,
    output logic                 wr_way,
    output cache_pkg::word_idx_t wr_word,
    output cache_pkg::word_t     wr_data,
    output logic                 set_dirty,
    output logic                 install_en,
    output logic                 install_way,
    output logic                 lru_touch,
    output logic                 touched_way,
    input  logic                 line_hit,
    input  logic                 hit_way,
    input  logic                 victim_way,
    input  logic                 victim_valid,
    input  logic                 victim_dirty,
    input  cache_pkg::tag_t      victim_tag,
    input  cache_pkg::word_t     rd_data
);

    cache_pkg::ctrl_state_t state;

    // Way being refilled, fixed for the whole miss
    logic way_q;
    cache_pkg::word_idx_t word_cnt;

    cache_pkg::word_idx_t addr_word;
    logic request;
    logic in_idle;
    logic idle_hit;
    logic last_word;
    logic [cache_pkg::data_width-cache_pkg::byte_width-1:0] line_word_addr;

    // Address split
    assign lookup_tag = address[cache_pkg::data_width-1 -: cache_pkg::tag_width];
    assign lookup_set = address[cache_pkg::byte_width+cache_pkg::offset_width +:
                                cache_pkg::set_width];
    assign addr_word  = address[cache_pkg::byte_width +: cache_pkg::offset_width];

    assign request  = load || store;
    assign in_idle  = (state == cache_pkg::idle);
    assign idle_hit = in_idle && line_hit;

    // Processor side
    assign hit      = idle_hit;
    assign miss     = in_idle && request && !line_hit;
    assign busy     = !in_idle;
    assign data_out = rd_data;

    // Idle reads the addressed word, write-back streams the victim line
    assign rd_way  = in_idle ? hit_way : way_q;
    assign rd_word = in_idle ? addr_word : word_cnt;

    // Store hits and fetched words share the word write port
    assign wr_en     = (idle_hit && store) || (state == cache_pkg::fetch && mem_ready);
    assign wr_way    = in_idle ? hit_way : way_q;
    assign wr_word   = in_idle ? addr_word : word_cnt;
    assign wr_data   = in_idle ? data_in : mem_data;
    assign set_dirty = in_idle;

    assign install_en  = (state == cache_pkg::install);
    assign install_way = way_q;

    assign lru_touch   = (idle_hit && request) || (state == cache_pkg::update);
    assign touched_way = in_idle ? hit_way : way_q;

    // Memory side
    assign mem_read       = (state == cache_pkg::fetch);
    assign mem_write      = (state == cache_pkg::write_back);
    assign mem_write_data = rd_data;

    always_comb begin
        if (state == cache_pkg::write_back) begin
            line_word_addr = {victim_tag, lookup_set, word_cnt};
        end else begin
            line_word_addr = {lookup_tag, lookup_set, word_cnt};
        end
    end

    // Only the low word-address bits reach the backing store
    assign mem_addr = mem_pkg::mem_addr_t'(line_word_addr);

    assign last_word = (word_cnt == cache_pkg::word_idx_t'(cache_pkg::line_size - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= cache_pkg::idle;
            way_q    <= 1'b0;
            word_cnt <= '0;
        end else begin
            case (state)
                cache_pkg::idle: begin
                    if (request && !line_hit) begin
                        way_q    <= victim_way;
                        word_cnt <= '0;
                        if (victim_valid && victim_dirty) begin
                            state <= cache_pkg::write_back;
                        end else begin
                            state <= cache_pkg::fetch;
                        end
                    end
                end

                cache_pkg::write_back: begin
                    if (mem_ready) begin
                        if (last_word) begin
                            word_cnt <= '0;
                            state    <= cache_pkg::fetch;
                        end else begin
                            word_cnt <= word_cnt + 1'b1;
                        end
                    end
                end

                cache_pkg::fetch: begin
                    if (mem_ready) begin
                        if (last_word) begin
                            word_cnt <= '0;
                            state    <= cache_pkg::install;
                        end else begin
                            word_cnt <= word_cnt + 1'b1;
                        end
                    end
                end

                cache_pkg::install: begin
                    state <= cache_pkg::update;
                end

                cache_pkg::update: begin
                    state <= cache_pkg::idle;
                end

                default: begin
                    state <= cache_pkg::idle;
                end
            endcase
        end
    end

endmodule

// File: hdl/cache_line_store.sv
`timescale 1ns/1ps

module cache_line_store (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cache_pkg::tag_t      lookup_tag,
    input  cache_pkg::set_idx_t  lookup_set,
    output logic                 hit,
    output logic                 hit_way,
    output logic                 victim_way,
    output logic                 victim_valid,
    output logic                 victim_dirty,
    output cache_pkg::tag_t      victim_tag,
    input  logic                 rd_way,
    input  cache_pkg::word_idx_t rd_word,
    output cache_pkg::word_t     rd_data,
    input  logic                 wr_en,
    input  logic                 wr_way,
    input  cache_pkg::word_idx_t wr_word,
    input  cache_pkg::word_t     wr_data,
    input  logic                 set_dirty,
    input  logic                 install_en,
    input  logic                 install_way,
    input  logic                 lru_touch,
    input  logic                 touched_way
);

    // Per set, one bit per way
    logic [cache_pkg::num_ways-1:0] valid_q [cache_pkg::num_sets];
    logic [cache_pkg::num_ways-1:0] dirty_q [cache_pkg::num_sets];

    // Per set, the way to replace next
    logic [cache_pkg::num_sets-1:0] lru_q;

    cache_pkg::tag_t  tag_q  [cache_pkg::num_sets][cache_pkg::num_ways];
    cache_pkg::word_t data_q [cache_pkg::num_sets][cache_pkg::num_ways][cache_pkg::line_size];

    logic way0_hit;
    logic way1_hit;

    assign way0_hit = valid_q[lookup_set][0] && (tag_q[lookup_set][0] == lookup_tag);
    assign way1_hit = valid_q[lookup_set][1] && (tag_q[lookup_set][1] == lookup_tag);

    // At most one way matches a given tag
    assign hit     = way0_hit || way1_hit;
    assign hit_way = way1_hit;

    // Empty ways are filled before anything is evicted
    always_comb begin
        if (!valid_q[lookup_set][0]) begin
            victim_way = 1'b0;
        end else if (!valid_q[lookup_set][1]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru_q[lookup_set];
        end
    end

    assign victim_valid = valid_q[lookup_set][victim_way];
    assign victim_dirty = dirty_q[lookup_set][victim_way];
    assign victim_tag   = tag_q[lookup_set][victim_way];

    assign rd_data = data_q[lookup_set][rd_way][rd_word];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < cache_pkg::num_sets; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
            lru_q <= '0;
        end else begin
            if (install_en) begin
                valid_q[lookup_set][install_way] <= 1'b1;
                dirty_q[lookup_set][install_way] <= 1'b0;
            end
            if (wr_en && set_dirty) begin
                dirty_q[lookup_set][wr_way] <= 1'b1;
            end
            // Other way becomes the victim
            if (lru_touch) begin
                lru_q[lookup_set] <= ~touched_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_q[lookup_set][wr_way][wr_word] <= wr_data;
        end
        if (install_en) begin
            tag_q[lookup_set][install_way] <= lookup_tag;
        end
    end

endmodule

// File: hdl/mem_pkg.sv
package mem_pkg;

    localparam int mem_words      = 1024;
    localparam int mem_addr_width = $clog2(mem_words);

    // Cycles a request must be steady before the ready pulse
    localparam int mem_latency    = 2;
    localparam int mem_lat_width  = $clog2(mem_latency + 1);

    typedef logic [mem_addr_width-1:0] mem_addr_t;

    // Low bits stay clear so every word address gives a distinct value
    localparam cache_pkg::word_t mem_init_pattern = 32'hc3a5_5800;

    // Content of each word after reset
    function automatic cache_pkg::word_t mem_init_word(mem_addr_t addr);
        return cache_pkg::word_t'(addr) ^ mem_init_pattern;
    endfunction

endpackage

// File: hdl/cache_pkg.sv
package cache_pkg;

    // Geometry
    localparam int data_width   = 32;
    localparam int set_width    = 3;
    localparam int line_size    = 4;
    localparam int num_ways     = 2;
    localparam int num_sets     = 2 ** set_width;

    // Address fields, low to high: byte, word in line, set, tag
    localparam int byte_width   = 2;
    localparam int offset_width = $clog2(line_size);
    localparam int tag_width    = data_width - set_width - offset_width - byte_width;

    typedef logic [data_width-1:0]   word_t;
    typedef logic [tag_width-1:0]    tag_t;
    typedef logic [set_width-1:0]    set_idx_t;
    typedef logic [offset_width-1:0] word_idx_t;

    // Miss sequence
    typedef enum logic [2:0] {
        idle,
        write_back,
        fetch,
        install,
        update
    } ctrl_state_t;

endpackage
